//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_bypass
FILELIST  = sim.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bypass_top.sv
`timescale 1ns/1ps

module bypass_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  rv32_pipe_pkg::opcode_t               id_opcode,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rd,
    input  logic [rv32_pipe_pkg::xlen-1:0]       id_rs1_data,
    input  logic [rv32_pipe_pkg::xlen-1:0]       id_rs2_data,
    input  logic [rv32_pipe_pkg::xlen-1:0]       ex_result,
    input  logic [rv32_pipe_pkg::xlen-1:0]       mem_rdata,
    output logic [rv32_pipe_pkg::xlen-1:0]       ex_op1,
    output logic [rv32_pipe_pkg::xlen-1:0]       ex_op2,
    output logic                                 stall,
    output logic                                 wb_we,
    output logic [rv32_pipe_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv32_pipe_pkg::xlen-1:0]       wb_data
);

    ctrl_if   ctrl_bus (.clk(clk));
    result_if res_bus ();

    ctrl_pipe u_ctrl_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .id_opcode (id_opcode),
        .id_rs1    (id_rs1),
        .id_rs2    (id_rs2),
        .id_rd     (id_rd),
        .ctrl      (ctrl_bus.source)
    );

    data_pipe u_data_pipe (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_rs1_data (id_rs1_data),
        .id_rs2_data (id_rs2_data),
        .ex_result   (ex_result),
        .mem_rdata   (mem_rdata),
        .ctrl        (ctrl_bus.sink),
        .res         (res_bus.source)
    );

    operand_bypass u_operand_bypass (
        .ctrl   (ctrl_bus.sink),
        .res    (res_bus.sink),
        .ex_op1 (ex_op1),
        .ex_op2 (ex_op2),
        .stall  (stall)
    );

    // Write-back port for the external register file.
    assign wb_we   = ctrl_bus.ctrlwb_at_wb.load_regfile;
    assign wb_rd   = ctrl_bus.ctrlwb_at_wb.rd;
    assign wb_data = res_bus.wb_value;

endmodule

//--- ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if (
    input logic clk
);

    rv32_pipe_pkg::ctrl_mem_t ctrlmem_at_id;
    rv32_pipe_pkg::ctrl_mem_t ctrlmem_at_ex;
    rv32_pipe_pkg::ctrl_mem_t ctrlmem_at_mem;  // Needed for the load-data choice at WB.
    rv32_pipe_pkg::ctrl_wb_t  ctrlwb_at_id;
    rv32_pipe_pkg::ctrl_wb_t  ctrlwb_at_ex;
    rv32_pipe_pkg::ctrl_wb_t  ctrlwb_at_mem;
    rv32_pipe_pkg::ctrl_wb_t  ctrlwb_at_wb;

    modport source (
        output ctrlmem_at_id, ctrlmem_at_ex, ctrlmem_at_mem,
        output ctrlwb_at_id, ctrlwb_at_ex, ctrlwb_at_mem, ctrlwb_at_wb
    );

    // The clock lets combinational consumers sample their checks.
    modport sink (
        input clk,
        input ctrlmem_at_id, ctrlmem_at_ex, ctrlmem_at_mem,
        input ctrlwb_at_id, ctrlwb_at_ex, ctrlwb_at_mem, ctrlwb_at_wb
    );

endinterface

//--- ctrl_pipe.sv
`timescale 1ns/1ps

module ctrl_pipe (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 stall,
    input  rv32_pipe_pkg::opcode_t               id_opcode,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [rv32_pipe_pkg::reg_addr_w-1:0] id_rd,
    ctrl_if.source                               ctrl
);

    logic id_writes_rd;

    // Every format with an rd field writes the register file.
    always_comb begin
        case (id_opcode)
            rv32_pipe_pkg::op_lui,
            rv32_pipe_pkg::op_auipc,
            rv32_pipe_pkg::op_jal,
            rv32_pipe_pkg::op_jalr,
            rv32_pipe_pkg::op_load,
            rv32_pipe_pkg::op_imm,
            rv32_pipe_pkg::op_reg:   id_writes_rd = 1'b1;
            default:                 id_writes_rd = 1'b0;
        endcase
    end

    assign ctrl.ctrlmem_at_id = '{opcode: id_opcode};

    assign ctrl.ctrlwb_at_id = '{
        rs1:          id_rs1,
        rs2:          id_rs2,
        rd:           id_rd,
        load_regfile: id_writes_rd
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.ctrlmem_at_ex  <= rv32_pipe_pkg::ctrl_mem_nop;
            ctrl.ctrlmem_at_mem <= rv32_pipe_pkg::ctrl_mem_nop;
            ctrl.ctrlwb_at_ex   <= rv32_pipe_pkg::ctrl_wb_nop;
            ctrl.ctrlwb_at_mem  <= rv32_pipe_pkg::ctrl_wb_nop;
            ctrl.ctrlwb_at_wb   <= rv32_pipe_pkg::ctrl_wb_nop;
        end else begin
            // The ID instruction waits a cycle and EX gets a bubble.
            if (stall) begin
                ctrl.ctrlmem_at_ex <= rv32_pipe_pkg::ctrl_mem_nop;
                ctrl.ctrlwb_at_ex  <= rv32_pipe_pkg::ctrl_wb_nop;
            end else begin
                ctrl.ctrlmem_at_ex <= ctrl.ctrlmem_at_id;
                ctrl.ctrlwb_at_ex  <= ctrl.ctrlwb_at_id;
            end
            ctrl.ctrlmem_at_mem <= ctrl.ctrlmem_at_ex;  // Later stages never hold.
            ctrl.ctrlwb_at_mem  <= ctrl.ctrlwb_at_ex;
            ctrl.ctrlwb_at_wb   <= ctrl.ctrlwb_at_mem;
        end
    end

    // A stalled cycle must leave a harmless bubble in EX behind it.
    ex_bubble_after_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> (ctrl.ctrlmem_at_ex == rv32_pipe_pkg::ctrl_mem_nop) &&
                  (ctrl.ctrlwb_at_ex == rv32_pipe_pkg::ctrl_wb_nop)
    );

endmodule

//--- data_pipe.sv
`timescale 1ns/1ps

module data_pipe (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [rv32_pipe_pkg::xlen-1:0] id_rs1_data,
    input  logic [rv32_pipe_pkg::xlen-1:0] id_rs2_data,
    input  logic [rv32_pipe_pkg::xlen-1:0] ex_result,
    input  logic [rv32_pipe_pkg::xlen-1:0] mem_rdata,
    ctrl_if.sink                           ctrl,
    result_if.source                       res
);

    logic mem_is_load;
    logic [rv32_pipe_pkg::xlen-1:0] wb_next;

    assign mem_is_load = (ctrl.ctrlmem_at_mem.opcode == rv32_pipe_pkg::op_load);

    // Loads retire the memory word, everything else the EX result.
    assign wb_next = mem_is_load ? mem_rdata : res.mem_value;

    // A bubble in EX may carry stale operands. Its control record writes nothing.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.ex_rs1_data <= '0;
            res.ex_rs2_data <= '0;
        end else begin
            res.ex_rs1_data <= id_rs1_data;
            res.ex_rs2_data <= id_rs2_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.mem_value <= '0;
        end else begin
            res.mem_value <= ex_result;  // For a load this is the address.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.wb_value <= '0;
        end else begin
            res.wb_value <= wb_next;
        end
    end

endmodule

//--- forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
    ctrl_if.sink                    ctrl,
    output logic                    hazard_exist,
    output rv32_pipe_pkg::fwd_sel_t fwdmux1_sel,
    output rv32_pipe_pkg::fwd_sel_t fwdmux2_sel
);

    logic ex_is_load;
    logic id_needs_load_rd;

    // Formats that read rs1. lui, auipc and jal have no source register.
    function automatic logic reads_rs1(input rv32_pipe_pkg::opcode_t op);
        return op inside {
            rv32_pipe_pkg::op_imm,
            rv32_pipe_pkg::op_reg,
            rv32_pipe_pkg::op_load,
            rv32_pipe_pkg::op_store,
            rv32_pipe_pkg::op_jalr,
            rv32_pipe_pkg::op_br
        };
    endfunction

    function automatic logic reads_rs2(input rv32_pipe_pkg::opcode_t op);
        return op inside {
            rv32_pipe_pkg::op_reg,
            rv32_pipe_pkg::op_store,
            rv32_pipe_pkg::op_br
        };
    endfunction

    // Writes to x0 are dropped, so they never count as a producer.
    function automatic logic is_producer(input rv32_pipe_pkg::ctrl_wb_t rec);
        return rec.load_regfile && (rec.rd != '0);
    endfunction

    // MEM holds the younger producer and takes priority over WB.
    function automatic rv32_pipe_pkg::fwd_sel_t pick_src(
        input logic                                 used,
        input logic [rv32_pipe_pkg::reg_addr_w-1:0] rs,
        input rv32_pipe_pkg::ctrl_wb_t              mem_rec,
        input rv32_pipe_pkg::ctrl_wb_t              wb_rec
    );
        if (used && is_producer(mem_rec) && (mem_rec.rd == rs))
            return rv32_pipe_pkg::fwd_mem;
        else if (used && is_producer(wb_rec) && (wb_rec.rd == rs))
            return rv32_pipe_pkg::fwd_wb;
        else
            return rv32_pipe_pkg::no_fwd;
    endfunction

    assign fwdmux1_sel = pick_src(reads_rs1(ctrl.ctrlmem_at_ex.opcode), ctrl.ctrlwb_at_ex.rs1,
                                  ctrl.ctrlwb_at_mem, ctrl.ctrlwb_at_wb);
    assign fwdmux2_sel = pick_src(reads_rs2(ctrl.ctrlmem_at_ex.opcode), ctrl.ctrlwb_at_ex.rs2,
                                  ctrl.ctrlwb_at_mem, ctrl.ctrlwb_at_wb);

    // Load data only exists at the end of MEM, one cycle too late for EX.
    assign ex_is_load = (ctrl.ctrlmem_at_ex.opcode == rv32_pipe_pkg::op_load) &&
                        (ctrl.ctrlwb_at_ex.rd != '0);

    assign id_needs_load_rd =
        (reads_rs1(ctrl.ctrlmem_at_id.opcode) && (ctrl.ctrlwb_at_ex.rd == ctrl.ctrlwb_at_id.rs1)) ||
        (reads_rs2(ctrl.ctrlmem_at_id.opcode) && (ctrl.ctrlwb_at_ex.rd == ctrl.ctrlwb_at_id.rs2));

    assign hazard_exist = ex_is_load && id_needs_load_rd;

    // x0 reads as zero, so bubbles and x0 sources must keep the register value.
    no_fwd_to_x0: assert property (
        @(posedge ctrl.clk)
        ((fwdmux1_sel != rv32_pipe_pkg::no_fwd) -> (ctrl.ctrlwb_at_ex.rs1 != '0)) &&
        ((fwdmux2_sel != rv32_pipe_pkg::no_fwd) -> (ctrl.ctrlwb_at_ex.rs2 != '0))
    );

endmodule

//--- operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    ctrl_if.sink                           ctrl,
    result_if.sink                         res,
    output logic [rv32_pipe_pkg::xlen-1:0] ex_op1,
    output logic [rv32_pipe_pkg::xlen-1:0] ex_op2,
    output logic                           stall
);

    rv32_pipe_pkg::fwd_sel_t fwdmux1_sel;
    rv32_pipe_pkg::fwd_sel_t fwdmux2_sel;
    logic                    hazard_exist;

    // Same three-way choice for both operands.
    function automatic logic [rv32_pipe_pkg::xlen-1:0] bypass_mux(
        input rv32_pipe_pkg::fwd_sel_t        sel,
        input logic [rv32_pipe_pkg::xlen-1:0] reg_val,
        input logic [rv32_pipe_pkg::xlen-1:0] mem_val,
        input logic [rv32_pipe_pkg::xlen-1:0] wb_val
    );
        case (sel)
            rv32_pipe_pkg::fwd_mem: return mem_val;
            rv32_pipe_pkg::fwd_wb:  return wb_val;
            default:                return reg_val;
        endcase
    endfunction

    forwarding_unit u_forwarding_unit (
        .ctrl         (ctrl),
        .hazard_exist (hazard_exist),
        .fwdmux1_sel  (fwdmux1_sel),
        .fwdmux2_sel  (fwdmux2_sel)
    );

    assign ex_op1 = bypass_mux(fwdmux1_sel, res.ex_rs1_data, res.mem_value, res.wb_value);
    assign ex_op2 = bypass_mux(fwdmux2_sel, res.ex_rs2_data, res.mem_value, res.wb_value);

    assign stall = hazard_exist;  // Load-use is the only interlock.

endmodule

//--- result_if.sv
`timescale 1ns/1ps

interface result_if;

    // Register-file values of the instruction now in EX.
    logic [rv32_pipe_pkg::xlen-1:0] ex_rs1_data;
    logic [rv32_pipe_pkg::xlen-1:0] ex_rs2_data;

    logic [rv32_pipe_pkg::xlen-1:0] mem_value;  // EX result one stage later.
    logic [rv32_pipe_pkg::xlen-1:0] wb_value;   // Load data or ALU result.

    modport source (
        output ex_rs1_data,
        output ex_rs2_data,
        output mem_value,
        output wb_value
    );

    modport sink (
        input ex_rs1_data,
        input ex_rs2_data,
        input mem_value,
        input wb_value
    );

endinterface

//--- rv32_pipe_pkg.sv
package rv32_pipe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes of RV32I as found in bits [6:0] of the instruction word.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_t;

    // Operand source chosen by the bypass muxes in EX.
    typedef enum logic [1:0] {
        no_fwd  = 2'b00,  // Register-file value captured at ID.
        fwd_mem = 2'b01,
        fwd_wb  = 2'b10
    } fwd_sel_t;

    // Control fields that are consumed up to the MEM stage.
    typedef struct packed {
        opcode_t opcode;
    } ctrl_mem_t;

    // Control fields that ride along to write-back.
    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic                  load_regfile;
    } ctrl_wb_t;

    // The bubble is the canonical nop, an addi that writes nothing.
    localparam ctrl_mem_t ctrl_mem_nop = '{
        opcode: op_imm
    };

    localparam ctrl_wb_t ctrl_wb_nop = '{
        rs1:          '0,
        rs2:          '0,
        rd:           '0,
        load_regfile: 1'b0
    };

endpackage

//--- sim.f
rv32_pipe_pkg.sv
ctrl_if.sv
result_if.sv
ctrl_pipe.sv
data_pipe.sv
forwarding_unit.sv
operand_bypass.sv
bypass_top.sv
tb_bypass.sv

//--- tb_bypass.sv
`timescale 1ns/1ps

module tb_bypass;

    localparam int n_rows         = 28;
    localparam int timeout_cycles = n_rows * 2 + 20;

    // Where an operand is expected to come from once its row sits in EX.
    localparam logic [1:0] src_reg = 2'd0;
    localparam logic [1:0] src_mem = 2'd1;
    localparam logic [1:0] src_wb  = 2'd2;

    typedef struct packed {
        rv32_pipe_pkg::opcode_t op;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
        logic                   stall;
        logic [1:0]             src1;
        logic [1:0]             src2;
    } row_t;

    logic                   clk;
    logic                   arst_n;
    rv32_pipe_pkg::opcode_t id_opcode;
    logic [4:0]             id_rs1;
    logic [4:0]             id_rs2;
    logic [4:0]             id_rd;
    logic [31:0]            id_rs1_data;
    logic [31:0]            id_rs2_data;
    logic [31:0]            ex_result;
    logic [31:0]            mem_rdata;
    logic [31:0]            ex_op1;
    logic [31:0]            ex_op2;
    logic                   stall;
    logic                   wb_we;
    logic [4:0]             wb_rd;
    logic [31:0]            wb_data;

    row_t rows [n_rows];
    int   error_count;
    int   cycle_count;
    int   idx;
    logic held;

    // Shadow pipeline of the reference model.
    rv32_pipe_pkg::opcode_t m_ex_op;
    rv32_pipe_pkg::opcode_t m_mem_op;
    logic [4:0]  m_ex_rs1, m_ex_rs2, m_ex_rd, m_mem_rd, m_wb_rd;
    logic        m_ex_we, m_mem_we, m_wb_we;
    logic [31:0] m_ex_d1, m_ex_d2, m_mem_val, m_wb_val;
    int          m_ex_row;
    logic [1:0]  sel1, sel2;
    logic [31:0] exp_op1, exp_op2;
    logic        exp_stall;

    bypass_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_opcode   (id_opcode),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_rd       (id_rd),
        .id_rs1_data (id_rs1_data),
        .id_rs2_data (id_rs2_data),
        .ex_result   (ex_result),
        .mem_rdata   (mem_rdata),
        .ex_op1      (ex_op1),
        .ex_op2      (ex_op2),
        .stall       (stall),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the table did not finish within %0d cycles.", timeout_cycles);
            stop_with_failure();
        end
    end

    function automatic logic needs_src1(input rv32_pipe_pkg::opcode_t op);
        case (op)
            rv32_pipe_pkg::op_imm, rv32_pipe_pkg::op_reg, rv32_pipe_pkg::op_load,
            rv32_pipe_pkg::op_store, rv32_pipe_pkg::op_jalr, rv32_pipe_pkg::op_br: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic needs_src2(input rv32_pipe_pkg::opcode_t op);
        case (op)
            rv32_pipe_pkg::op_reg, rv32_pipe_pkg::op_store, rv32_pipe_pkg::op_br: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic writes_dest(input rv32_pipe_pkg::opcode_t op);
        case (op)
            rv32_pipe_pkg::op_lui, rv32_pipe_pkg::op_auipc, rv32_pipe_pkg::op_jal,
            rv32_pipe_pkg::op_jalr, rv32_pipe_pkg::op_load, rv32_pipe_pkg::op_imm,
            rv32_pipe_pkg::op_reg: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // The younger writer in MEM shadows an older one in WB.
    function automatic logic [1:0] pick_source(input logic used, input logic [4:0] rs);
        if (used && m_mem_we && (m_mem_rd != '0) && (m_mem_rd == rs))
            return src_mem;
        else if (used && m_wb_we && (m_wb_rd != '0) && (m_wb_rd == rs))
            return src_wb;
        else
            return src_reg;
    endfunction

    function automatic logic [31:0] source_value(input logic [1:0] sel, input logic [31:0] rf);
        if (sel == src_mem)
            return m_mem_val;
        else if (sel == src_wb)
            return m_wb_val;
        else
            return rf;
    endfunction

    task automatic stop_with_failure();
        error_count++;
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{rv32_pipe_pkg::op_imm,   5'd1,  5'd0,  5'd5,  1'b0, src_reg, src_reg};
        rows[1]  = '{rv32_pipe_pkg::op_reg,   5'd5,  5'd2,  5'd6,  1'b0, src_mem, src_reg};
        rows[2]  = '{rv32_pipe_pkg::op_reg,   5'd5,  5'd6,  5'd7,  1'b0, src_wb,  src_mem};
        rows[3]  = '{rv32_pipe_pkg::op_imm,   5'd7,  5'd7,  5'd7,  1'b0, src_mem, src_reg};
        rows[4]  = '{rv32_pipe_pkg::op_reg,   5'd7,  5'd3,  5'd8,  1'b0, src_mem, src_reg};
        rows[5]  = '{rv32_pipe_pkg::op_imm,   5'd0,  5'd0,  5'd0,  1'b0, src_reg, src_reg};
        rows[6]  = '{rv32_pipe_pkg::op_reg,   5'd0,  5'd0,  5'd9,  1'b0, src_reg, src_reg};
        rows[7]  = '{rv32_pipe_pkg::op_load,  5'd9,  5'd9,  5'd10, 1'b0, src_mem, src_reg};
        rows[8]  = '{rv32_pipe_pkg::op_reg,   5'd10, 5'd1,  5'd11, 1'b1, src_wb,  src_reg};
        rows[9]  = '{rv32_pipe_pkg::op_store, 5'd2,  5'd11, 5'd0,  1'b0, src_reg, src_mem};
        rows[10] = '{rv32_pipe_pkg::op_jalr,  5'd11, 5'd11, 5'd1,  1'b0, src_wb,  src_reg};
        rows[11] = '{rv32_pipe_pkg::op_load,  5'd1,  5'd0,  5'd12, 1'b0, src_mem, src_reg};
        rows[12] = '{rv32_pipe_pkg::op_store, 5'd3,  5'd12, 5'd0,  1'b1, src_reg, src_wb};
        rows[13] = '{rv32_pipe_pkg::op_load,  5'd12, 5'd0,  5'd13, 1'b0, src_reg, src_reg};
        rows[14] = '{rv32_pipe_pkg::op_imm,   5'd13, 5'd13, 5'd14, 1'b1, src_wb,  src_reg};
        rows[15] = '{rv32_pipe_pkg::op_br,    5'd14, 5'd13, 5'd0,  1'b0, src_mem, src_reg};
        rows[16] = '{rv32_pipe_pkg::op_load,  5'd0,  5'd5,  5'd0,  1'b0, src_reg, src_reg};
        rows[17] = '{rv32_pipe_pkg::op_reg,   5'd0,  5'd0,  5'd15, 1'b0, src_reg, src_reg};
        rows[18] = '{rv32_pipe_pkg::op_lui,   5'd15, 5'd15, 5'd16, 1'b0, src_reg, src_reg};
        rows[19] = '{rv32_pipe_pkg::op_jal,   5'd0,  5'd0,  5'd17, 1'b0, src_reg, src_reg};
        rows[20] = '{rv32_pipe_pkg::op_reg,   5'd16, 5'd17, 5'd18, 1'b0, src_wb,  src_mem};
        rows[21] = '{rv32_pipe_pkg::op_load,  5'd18, 5'd0,  5'd19, 1'b0, src_mem, src_reg};
        rows[22] = '{rv32_pipe_pkg::op_br,    5'd19, 5'd19, 5'd0,  1'b1, src_wb,  src_wb};
        rows[23] = '{rv32_pipe_pkg::op_csr,   5'd19, 5'd0,  5'd20, 1'b0, src_reg, src_reg};
        for (int i = 24; i < n_rows; i++) begin
            rows[i] = '{rv32_pipe_pkg::op_imm, 5'd0, 5'd0, 5'd0, 1'b0, src_reg, src_reg};
        end
    endtask

    initial begin
        void'($urandom(32'h335e_c68f));
        clk = 1'b0;
        arst_n = 1'b0;
        id_opcode = rv32_pipe_pkg::op_imm;
        id_rs1 = '0;
        id_rs2 = '0;
        id_rd = '0;
        id_rs1_data = '0;
        id_rs2_data = '0;
        ex_result = '0;
        mem_rdata = '0;
        error_count = 0;
        cycle_count = 0;
        idx = 0;
        held = 1'b0;
        // Reset state of the model. A bubble is an addi to x0.
        m_ex_op = rv32_pipe_pkg::op_imm;
        m_mem_op = rv32_pipe_pkg::op_imm;
        {m_ex_rs1, m_ex_rs2, m_ex_rd, m_mem_rd, m_wb_rd} = '0;
        {m_ex_we, m_mem_we, m_wb_we} = '0;
        {m_ex_d1, m_ex_d2, m_mem_val, m_wb_val} = '0;
        m_ex_row = -1;
        fill_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (idx < n_rows) begin
            if (!held) begin  // A stalled row keeps its inputs and data.
                id_opcode = rows[idx].op;
                id_rs1 = rows[idx].rs1;
                id_rs2 = rows[idx].rs2;
                id_rd = rows[idx].rd;
                id_rs1_data = $urandom;
                id_rs2_data = $urandom;
            end
            ex_result = $urandom;
            mem_rdata = $urandom;
            #1;

            sel1 = pick_source(needs_src1(m_ex_op), m_ex_rs1);
            sel2 = pick_source(needs_src2(m_ex_op), m_ex_rs2);
            exp_op1 = source_value(sel1, m_ex_d1);
            exp_op2 = source_value(sel2, m_ex_d2);
            exp_stall = (m_ex_op == rv32_pipe_pkg::op_load) && (m_ex_rd != '0) &&
                        ((needs_src1(id_opcode) && (id_rs1 == m_ex_rd)) ||
                         (needs_src2(id_opcode) && (id_rs2 == m_ex_rd)));

            if (m_ex_row >= 0) begin
                assert ((sel1 == rows[m_ex_row].src1) && (sel2 == rows[m_ex_row].src2)) else begin
                    $display("Row %0d in EX takes its operands from %0d/%0d, the table says %0d/%0d.",
                             m_ex_row, sel1, sel2, rows[m_ex_row].src1, rows[m_ex_row].src2);
                    stop_with_failure();
                end
            end
            if (!held) begin
                assert (exp_stall == rows[idx].stall) else begin
                    $display("Row %0d at ID should %0sstall by the table.",
                             idx, rows[idx].stall ? "" : "not ");
                    stop_with_failure();
                end
            end

            check_value("stall", 32'(stall), 32'(exp_stall));
            check_value("ex_op1", ex_op1, exp_op1);
            check_value("ex_op2", ex_op2, exp_op2);
            check_value("wb_we", 32'(wb_we), 32'(m_wb_we));
            check_value("wb_rd", 32'(wb_rd), 32'(m_wb_rd));
            check_value("wb_data", wb_data, m_wb_val);

            // Advance the model by the coming rising edge, oldest stage first.
            m_wb_we = m_mem_we;
            m_wb_rd = m_mem_rd;
            m_wb_val = (m_mem_op == rv32_pipe_pkg::op_load) ? mem_rdata : m_mem_val;
            m_mem_op = m_ex_op;
            m_mem_rd = m_ex_rd;
            m_mem_we = m_ex_we;
            m_mem_val = ex_result;
            m_ex_d1 = id_rs1_data;
            m_ex_d2 = id_rs2_data;
            if (exp_stall) begin
                m_ex_op = rv32_pipe_pkg::op_imm;
                {m_ex_rs1, m_ex_rs2, m_ex_rd} = '0;
                m_ex_we = 1'b0;
                m_ex_row = -1;
            end else begin
                m_ex_op = id_opcode;
                m_ex_rs1 = id_rs1;
                m_ex_rs2 = id_rs2;
                m_ex_rd = id_rd;
                m_ex_we = writes_dest(id_opcode);
                m_ex_row = idx;
                idx++;
            end
            held = exp_stall;
            @(negedge clk);
        end

        if (error_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule
